//--- hw/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// timer window, inclusive at both ends
`define LSU_DEV_CLINT     32'h0200_0000
`define LSU_DEV_CLINT_END 32'h0200_ffff
`define LSU_MTIME_LO      16'hbff8
`define LSU_MTIME_HI      16'hbffc

// sram window, one word per entry
`define LSU_SRAM_BASE     32'h8000_0000
`define LSU_SRAM_WORDS    256

`endif

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // access width of a request, none makes no bus access
    typedef enum logic [1:0] {
        size_none = 2'd0,
        size_byte = 2'd1,
        size_half = 2'd2,
        size_word = 2'd3
    } size_t;

    // response codes as on the AXI-lite b and r channels
    typedef enum logic [1:0] {
        resp_okay   = 2'd0,
        resp_slverr = 2'd2,
        resp_decerr = 2'd3
    } resp_t;

endpackage

`default_nettype wire

//--- hw/lsu_align.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_align (
    input  lsu_pkg::size_t size,
    input  logic           sign,
    input  logic [1:0]     addr_lo,
    input  logic [31:0]    wdata,
    input  logic [31:0]    rword,
    output logic [31:0]    wdata_lane,
    output logic [3:0]     wstrb,
    output logic [31:0]    rdata_ext
);
    import lsu_pkg::*;

    logic [31:0] rshift;

    assign wdata_lane = wdata << {addr_lo, 3'b000};  // store data into its byte lane
    assign rshift     = rword >> {addr_lo, 3'b000};  // loaded lane down to bit 0

    always_comb begin
        wstrb     = 4'b0000;
        rdata_ext = '0;
        case (size)
            size_byte: begin
                wstrb     = 4'b0001 << addr_lo;
                rdata_ext = {{24{sign & rshift[7]}}, rshift[7:0]};
            end
            size_half: begin
                wstrb     = addr_lo[1] ? 4'b1100 : 4'b0011;
                rdata_ext = {{16{sign & rshift[15]}}, rshift[15:0]};
            end
            size_word: begin
                wstrb     = 4'b1111;
                rdata_ext = rshift;
            end
            default: begin
                wstrb     = 4'b0000;  // no access
                rdata_ext = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/lsu_core.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_core (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ren,
    input  logic           wen,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata_lane,
    input  logic [3:0]     wstrb,
    input  logic [31:0]    rdata_ext,
    input  logic           arready,
    input  logic           rvalid,
    input  logic [31:0]    rdata_bus,
    input  lsu_pkg::resp_t rresp,
    input  logic           awready,
    input  logic           wready,
    input  logic           bvalid,
    input  lsu_pkg::resp_t bresp,
    output lsu_pkg::size_t al_size,
    output logic           al_sign,
    output logic [1:0]     al_addr_lo,
    output logic [31:0]    rword,
    output logic [31:0]    rdata,
    output logic           done,
    output logic           err,
    output logic           busy,
    output logic           arvalid,
    output logic [31:0]    araddr,
    output logic           rready,
    output logic           awvalid,
    output logic [31:0]    awaddr,
    output logic           wvalid,
    output logic [31:0]    wdata,
    output logic [3:0]     wstrb_out,
    output logic           bready
);
    import lsu_pkg::*;

    localparam logic [2:0] st_idle = 3'd0;
    localparam logic [2:0] st_ar   = 3'd1;
    localparam logic [2:0] st_r    = 3'd2;
    localparam logic [2:0] st_ext  = 3'd3;
    localparam logic [2:0] st_aw   = 3'd4;
    localparam logic [2:0] st_w    = 3'd5;
    localparam logic [2:0] st_b    = 3'd6;
    localparam logic [2:0] st_done = 3'd7;

    logic [2:0]  state;
    logic        err_q;
    logic [31:0] addr_q;
    size_t       size_q;
    logic        sign_q;
    logic        accept;
    logic        misaligned;

    assign accept     = (state == st_idle) && (ren || wen);
    assign misaligned = ((size == size_half) && addr[0]) ||
                        ((size == size_word) && (addr[1:0] != 2'b00));

    // aligner sees the live request at accept, the held one afterwards
    assign al_size    = busy ? size_q : size;
    assign al_sign    = busy ? sign_q : sign;
    assign al_addr_lo = busy ? addr_q[1:0] : addr[1:0];

    assign busy    = (state != st_idle);
    assign done    = (state == st_done);
    assign err     = done && err_q;
    assign arvalid = (state == st_ar);
    assign awvalid = (state == st_aw);
    assign wvalid  = (state == st_w);
    assign araddr  = addr_q;
    assign awaddr  = addr_q;
    assign rready  = 1'b1;
    assign bready  = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            err_q <= 1'b0;
            rdata <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        err_q <= misaligned;
                        if (misaligned || (size == size_none))
                            state <= st_done;  // no bus access
                        else if (ren)
                            state <= st_ar;  // read wins over write
                        else
                            state <= st_aw;
                    end
                end
                st_ar: if (arready) state <= st_r;
                st_r: begin
                    if (rvalid && rready) begin
                        err_q <= (rresp != resp_okay);
                        state <= st_ext;
                    end
                end
                st_ext: begin
                    rdata <= rdata_ext;
                    state <= st_done;
                end
                st_aw: if (awready) state <= st_w;
                st_w: if (wready) state <= st_b;
                st_b: begin
                    if (bvalid && bready) begin
                        err_q <= (bresp != resp_okay);
                        state <= st_done;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q    <= addr;
            size_q    <= size;
            sign_q    <= sign;
            wdata     <= wdata_lane;
            wstrb_out <= wstrb;
        end
        if ((state == st_r) && rvalid && rready)
            rword <= rdata_bus;
    end

endmodule

`default_nettype wire

//--- hw/lsu_xbar.sv
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_xbar (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           arvalid,
    input  logic [31:0]    araddr,
    output logic           arready,
    output logic           rvalid,
    output logic [31:0]    rdata,
    output lsu_pkg::resp_t rresp,
    input  logic           rready,
    input  logic           awvalid,
    input  logic [31:0]    awaddr,
    output logic           awready,
    input  logic           wvalid,
    output logic           wready,
    output logic           bvalid,
    output lsu_pkg::resp_t bresp,
    input  logic           bready,
    output logic           t_arvalid,
    input  logic           t_arready,
    input  logic           t_rvalid,
    input  logic [31:0]    t_rdata,
    input  lsu_pkg::resp_t t_rresp,
    output logic           s_arvalid,
    input  logic           s_arready,
    input  logic           s_rvalid,
    input  logic [31:0]    s_rdata,
    input  lsu_pkg::resp_t s_rresp,
    output logic           s_awvalid,
    input  logic           s_awready,
    output logic           s_wvalid,
    input  logic           s_wready,
    input  logic           s_bvalid,
    input  lsu_pkg::resp_t s_bresp
);
    import lsu_pkg::*;

    localparam logic [31:0] sram_bytes = 32'(`LSU_SRAM_WORDS * 4);

    logic r_clint;
    logic r_sram;
    logic w_sram;
    logic d_rvalid;
    logic d_bvalid;

    assign r_clint = (araddr >= `LSU_DEV_CLINT) && (araddr <= `LSU_DEV_CLINT_END);
    assign r_sram  = (araddr - `LSU_SRAM_BASE) < sram_bytes;
    assign w_sram  = (awaddr - `LSU_SRAM_BASE) < sram_bytes;  // timer takes no writes

    assign t_arvalid = arvalid && r_clint;
    assign s_arvalid = arvalid && r_sram;
    assign arready   = r_clint ? t_arready : (r_sram ? s_arready : 1'b1);
    assign rvalid    = r_clint ? t_rvalid  : (r_sram ? s_rvalid  : d_rvalid);
    assign rdata     = r_clint ? t_rdata   : (r_sram ? s_rdata   : 32'h0);
    assign rresp     = r_clint ? t_rresp   : (r_sram ? s_rresp   : resp_decerr);

    assign s_awvalid = awvalid && w_sram;
    assign s_wvalid  = wvalid && w_sram;
    assign awready   = w_sram ? s_awready : 1'b1;
    assign wready    = w_sram ? s_wready  : 1'b1;
    assign bvalid    = w_sram ? s_bvalid  : d_bvalid;
    assign bresp     = w_sram ? s_bresp   : resp_decerr;

    // local error responder for unmapped targets
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_rvalid <= 1'b0;
            d_bvalid <= 1'b0;
        end else begin
            if (arvalid && !r_clint && !r_sram)
                d_rvalid <= 1'b1;
            else if (rready)
                d_rvalid <= 1'b0;
            if (wvalid && !w_sram)
                d_bvalid <= 1'b1;  // aw already taken at once
            else if (bready)
                d_bvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/clint_timer.sv
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module clint_timer (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [15:0]    araddr,
    input  logic           arvalid,
    input  logic           rready,
    output logic           arready,
    output logic           rvalid,
    output logic [31:0]    rdata,
    output lsu_pkg::resp_t rresp
);
    import lsu_pkg::*;

    logic [63:0] mtime;

    assign arready = !rvalid;  // one read outstanding
    assign rresp   = resp_okay;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime  <= '0;
            rvalid <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (arvalid && arready)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // word sampled at the ar transfer
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            case (araddr)
                `LSU_MTIME_LO: rdata <= mtime[31:0];
                `LSU_MTIME_HI: rdata <= mtime[63:32];
                default:       rdata <= 32'h0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/sram_slave.sv
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module sram_slave #(
    parameter int words = `LSU_SRAM_WORDS
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [31:0]    araddr,
    input  logic           arvalid,
    input  logic           rready,
    input  logic [31:0]    awaddr,
    input  logic           awvalid,
    input  logic           wvalid,
    input  logic [31:0]    wdata,
    input  logic [3:0]     wstrb,
    input  logic           bready,
    output logic           arready,
    output logic           rvalid,
    output logic [31:0]    rdata,
    output lsu_pkg::resp_t rresp,
    output logic           awready,
    output logic           wready,
    output logic           bvalid,
    output lsu_pkg::resp_t bresp
);
    import lsu_pkg::*;

    localparam int addr_bits = $clog2(words);

    logic [31:0]          mem [words];
    logic [addr_bits-1:0] waddr_q;
    logic                 aw_done;  // address taken, waiting for data

    assign arready = !rvalid;
    assign awready = !aw_done && !bvalid;
    assign wready  = aw_done;
    assign rresp   = resp_okay;
    assign bresp   = resp_okay;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            aw_done <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (arvalid && arready)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
            if (awvalid && awready)
                aw_done <= 1'b1;
            else if (wvalid && wready)
                aw_done <= 1'b0;
            if (wvalid && wready)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready)
            rdata <= mem[araddr[addr_bits+1:2]];
        if (awvalid && awready)
            waddr_q <= awaddr[addr_bits+1:2];
        if (wvalid && wready) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i])
                    mem[waddr_q][8*i +: 8] <= wdata[8*i +: 8];  // strobed bytes only
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ren,
    input  logic           wen,
    input  logic           sign,
    input  lsu_pkg::size_t size,
    input  logic [31:0]    addr,
    input  logic [31:0]    wdata,
    output logic [31:0]    rdata,
    output logic           done,
    output logic           err,
    output logic           busy
);
    import lsu_pkg::*;

    size_t       al_size;
    logic        al_sign;
    logic [1:0]  al_addr_lo;
    logic [31:0] wdata_lane;
    logic [3:0]  wstrb;
    logic [31:0] rword;
    logic [31:0] rdata_ext;

    logic        arvalid, arready, rvalid, rready;
    logic [31:0] araddr, rdata_bus;
    resp_t       rresp;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic [31:0] awaddr, wdata_bus;
    logic [3:0]  wstrb_bus;
    resp_t       bresp;

    logic        t_arvalid, t_arready, t_rvalid;
    logic [31:0] t_rdata;
    resp_t       t_rresp;
    logic        s_arvalid, s_arready, s_rvalid;
    logic [31:0] s_rdata;
    resp_t       s_rresp;
    logic        s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid;
    resp_t       s_bresp;

    lsu_core i_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .ren        (ren),
        .wen        (wen),
        .sign       (sign),
        .size       (size),
        .addr       (addr),
        .wdata_lane (wdata_lane),
        .wstrb      (wstrb),
        .rdata_ext  (rdata_ext),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata_bus  (rdata_bus),
        .rresp      (rresp),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .al_size    (al_size),
        .al_sign    (al_sign),
        .al_addr_lo (al_addr_lo),
        .rword      (rword),
        .rdata      (rdata),
        .done       (done),
        .err        (err),
        .busy       (busy),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .rready     (rready),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wdata      (wdata_bus),
        .wstrb_out  (wstrb_bus),
        .bready     (bready)
    );

    lsu_align i_align (
        .size       (al_size),
        .sign       (al_sign),
        .addr_lo    (al_addr_lo),
        .wdata      (wdata),
        .rword      (rword),
        .wdata_lane (wdata_lane),
        .wstrb      (wstrb),
        .rdata_ext  (rdata_ext)
    );

    lsu_xbar i_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata_bus),
        .rresp     (rresp),
        .rready    (rready),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awready   (awready),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bresp     (bresp),
        .bready    (bready),
        .t_arvalid (t_arvalid),
        .t_arready (t_arready),
        .t_rvalid  (t_rvalid),
        .t_rdata   (t_rdata),
        .t_rresp   (t_rresp),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rvalid  (s_rvalid),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bvalid  (s_bvalid),
        .s_bresp   (s_bresp)
    );

    clint_timer i_clint (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr[15:0]),
        .arvalid (t_arvalid),
        .rready  (rready),
        .arready (t_arready),
        .rvalid  (t_rvalid),
        .rdata   (t_rdata),
        .rresp   (t_rresp)
    );

    sram_slave i_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (s_arvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (s_awvalid),
        .wvalid  (s_wvalid),
        .wdata   (wdata_bus),
        .wstrb   (wstrb_bus),
        .bready  (bready),
        .arready (s_arready),
        .rvalid  (s_rvalid),
        .rdata   (s_rdata),
        .rresp   (s_rresp),
        .awready (s_awready),
        .wready  (s_wready),
        .bvalid  (s_bvalid),
        .bresp   (s_bresp)
    );

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/lsu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        done,
    input logic        busy,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] awaddr,
    input logic        wvalid,
    input logic        wready,
    input logic [31:0] wdata
);

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before the ar transfer");

    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before the aw transfer");

    w_held: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("wvalid or wdata changed before the w transfer");

    busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
        busy && !done |=> busy)
        else $error("busy dropped before the request completed");

endmodule

bind lsu_core lsu_checker i_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .done    (done),
    .busy    (busy),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata)
);

`default_nettype wire

//--- verif/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "lsu_macros.svh"

module lsu_tb;
    import lsu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        ren;
    logic        wen;
    logic        sign;
    size_t       size;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        done;
    logic        err;
    logic        busy;

    int          seed = 53244;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] model [256];  // expected sram contents

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    lsu_top i_dut (
        .clk   (clk),
        .rst_n (rst_n),
        .ren   (ren),
        .wen   (wen),
        .sign  (sign),
        .size  (size),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .done  (done),
        .err   (err),
        .busy  (busy)
    );

    function automatic logic [31:0] sram_addr(input int idx, input int off);
        return `LSU_SRAM_BASE + idx * 4 + off;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic print_result(input string name, input int start);
        if (errors == start)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - start);
    endtask

    // store lands in the bytes starting at the offset
    task automatic update_model(input size_t sz, input logic [31:0] a, input logic [31:0] d);
        int off;
        off = a[1:0];
        case (sz)
            size_byte: model[a[9:2]][8*off +: 8] = d[7:0];
            size_half: model[a[9:2]][8*off +: 16] = d[15:0];
            size_word: model[a[9:2]] = d;
            default:   ;
        endcase
    endtask

    function automatic logic [31:0] expected_load(input size_t sz, input logic sg,
                                                  input logic [31:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        int          off;
        off = a[1:0];
        case (sz)
            size_byte: begin
                b = model[a[9:2]][8*off +: 8];
                if (sg && b[7])
                    return {24'hff_ffff, b};
                return {24'h0, b};
            end
            size_half: begin
                h = model[a[9:2]][8*off +: 16];
                if (sg && h[15])
                    return {16'hffff, h};
                return {16'h0, h};
            end
            default: return model[a[9:2]];
        endcase
    endfunction

    // issue one request and poll done at the falling edge
    task automatic issue(input logic rd, input size_t sz, input logic sg, input logic [31:0] a,
                         input logic [31:0] wd, output logic [31:0] got_data,
                         output logic got_err);
        int n;
        @(posedge clk);
        ren   <= rd;
        wen   <= !rd;
        size  <= sz;
        sign  <= sg;
        addr  <= a;
        wdata <= wd;
        @(posedge clk);
        ren <= 1'b0;
        wen <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < 50);
        if (!done) begin
            $display("timeout waiting for done, address %h", a);
            errors++;
        end
        got_data = rdata;
        got_err  = err;
    endtask

    task automatic store(input size_t sz, input logic [31:0] a, input logic [31:0] d);
        logic [31:0] q;
        logic        e;
        issue(1'b0, sz, 1'b0, a, d, q, e);
        check_value("err", 32'd0, {31'd0, e});
        update_model(sz, a, d);
    endtask

    task automatic load_check(input size_t sz, input logic sg, input logic [31:0] a);
        logic [31:0] q;
        logic        e;
        issue(1'b1, sz, sg, a, 32'h0, q, e);
        check_value("err", 32'd0, {31'd0, e});
        check_value("rdata", expected_load(sz, sg, a), q);
    endtask

    task automatic fill_sram();
        int start;
        start = errors;
        for (int i = 0; i < 256; i++)
            store(size_word, sram_addr(i, 0), 32'h9e37_79b9 * (i + 1));
        print_result("fill_sram", start);
    endtask

    task automatic word_roundtrip();
        int          start;
        logic [31:0] r;
        start = errors;
        repeat (8) begin
            r = $random(seed);
            store(size_word, sram_addr(r[7:0], 0), $random(seed));
            load_check(size_word, 1'b0, sram_addr(r[7:0], 0));
        end
        print_result("word_roundtrip", start);
    endtask

    task automatic subword_stores();
        int start;
        start = errors;
        for (int off = 0; off < 4; off++) begin
            store(size_byte, sram_addr(30, off), $random(seed));
            load_check(size_word, 1'b0, sram_addr(30, 0));
        end
        store(size_half, sram_addr(31, 0), $random(seed));
        load_check(size_word, 1'b0, sram_addr(31, 0));
        store(size_half, sram_addr(31, 2), $random(seed));
        load_check(size_word, 1'b0, sram_addr(31, 0));
        print_result("subword_stores", start);
    endtask

    task automatic subword_loads();
        int start;
        start = errors;
        store(size_word, sram_addr(20, 0), 32'h8a7f_f012);  // both sign polarities
        store(size_word, sram_addr(21, 0), $random(seed));
        for (int w = 20; w < 22; w++) begin
            for (int sg = 0; sg < 2; sg++) begin
                for (int off = 0; off < 4; off++)
                    load_check(size_byte, sg[0], sram_addr(w, off));
                load_check(size_half, sg[0], sram_addr(w, 0));
                load_check(size_half, sg[0], sram_addr(w, 2));
            end
        end
        print_result("subword_loads", start);
    endtask

    task automatic timer_reads();
        int          start;
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] q;
        logic        e;
        start = errors;
        issue(1'b1, size_word, 1'b0, `LSU_DEV_CLINT + `LSU_MTIME_HI, 32'h0, q, e);
        check_value("err", 32'd0, {31'd0, e});
        check_value("rdata", 32'h0, q);
        issue(1'b1, size_word, 1'b0, `LSU_DEV_CLINT + `LSU_MTIME_LO, 32'h0, t1, e);
        check_value("err", 32'd0, {31'd0, e});
        issue(1'b1, size_word, 1'b0, `LSU_DEV_CLINT + `LSU_MTIME_LO, 32'h0, t2, e);
        check_value("err", 32'd0, {31'd0, e});
        checks++;
        if (!(t2 > t1)) begin
            $display("mtime low word did not increase between reads: %h then %h", t1, t2);
            errors++;
        end
        issue(1'b0, size_word, 1'b0, `LSU_DEV_CLINT + `LSU_MTIME_LO, 32'h1234_5678, q, e);
        check_value("err", 32'd1, {31'd0, e});  // timer is read only
        print_result("timer_reads", start);
    endtask

    task automatic error_cases();
        int          start;
        logic [31:0] q;
        logic        e;
        start = errors;
        issue(1'b0, size_half, 1'b0, sram_addr(5, 1), 32'hffff_ffff, q, e);
        check_value("err", 32'd1, {31'd0, e});
        issue(1'b0, size_word, 1'b0, sram_addr(6, 2), 32'hffff_ffff, q, e);
        check_value("err", 32'd1, {31'd0, e});
        issue(1'b1, size_word, 1'b0, sram_addr(7, 3), 32'h0, q, e);
        check_value("err", 32'd1, {31'd0, e});
        issue(1'b1, size_word, 1'b0, 32'h4000_0000, 32'h0, q, e);
        check_value("err", 32'd1, {31'd0, e});
        check_value("rdata", 32'h0, q);
        issue(1'b0, size_word, 1'b0, sram_addr(256, 0), 32'hdead_beef, q, e);  // past the sram
        check_value("err", 32'd1, {31'd0, e});
        issue(1'b0, size_none, 1'b0, sram_addr(5, 0), 32'hffff_ffff, q, e);
        check_value("err", 32'd0, {31'd0, e});
        for (int w = 5; w < 8; w++)
            load_check(size_word, 1'b0, sram_addr(w, 0));
        load_check(size_word, 1'b0, sram_addr(0, 0));
        print_result("error_cases", start);
    endtask

    task automatic busy_ignore();
        int start;
        int n;
        int dones;
        start = errors;
        @(posedge clk);
        ren  <= 1'b1;
        size <= size_word;
        sign <= 1'b0;
        addr <= sram_addr(40, 0);
        @(posedge clk);
        ren   <= 1'b0;
        wen   <= 1'b1;  // stray strobe while the read runs
        addr  <= sram_addr(41, 0);
        wdata <= ~model[41];
        @(posedge clk);
        wen <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < 50);
        if (!done) begin
            $display("timeout waiting for done on the read issued before the stray write");
            errors++;
        end else begin
            check_value("err", 32'd0, {31'd0, err});
            check_value("rdata", model[40], rdata);
        end
        dones = 0;
        repeat (12) begin
            @(negedge clk);
            if (done)
                dones++;
        end
        checks++;
        if (dones != 0) begin
            $display("extra done seen after a request issued while busy");
            errors++;
        end
        check_value("busy", 32'd0, {31'd0, busy});
        load_check(size_word, 1'b0, sram_addr(41, 0));
        print_result("busy_ignore", start);
    endtask

    initial begin
        int n;
        ren   = 1'b0;
        wen   = 1'b0;
        sign  = 1'b0;
        size  = size_none;
        addr  = 32'h0;
        wdata = 32'h0;
        n = 0;
        while (!rst_n && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("reset was never released");
            errors++;
        end
        @(negedge clk);
        check_value("done", 32'd0, {31'd0, done});
        check_value("err", 32'd0, {31'd0, err});
        check_value("busy", 32'd0, {31'd0, busy});
        check_value("rdata", 32'h0, rdata);
        fill_sram();
        word_roundtrip();
        subword_stores();
        subword_loads();
        timer_reads();
        error_cases();
        busy_ignore();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_align.sv
hw/lsu_core.sv
hw/lsu_xbar.sv
hw/clint_timer.sv
hw/sram_slave.sv
hw/lsu_top.sv
verif/tb_clk_gen.sv
verif/lsu_checker.sv
verif/lsu_tb.sv
